/* hdl/bubble_prof_pkg.sv */
`default_nettype none

package bubble_prof_pkg;

  localparam int pc_width = 32;
  typedef logic [pc_width-1:0] pc_t;

  // execute stall causes, bit 0 wins
  localparam int num_stall_causes = 14;
  typedef logic [num_stall_causes-1:0] stall_vec_t;

  localparam int stall_long_op       = 0;
  localparam int stall_local_load    = 1;
  localparam int stall_imul          = 2;
  localparam int stall_amo_aq        = 3;
  localparam int stall_amo_rl        = 4;
  localparam int stall_bypass        = 5;
  localparam int stall_lr_aq         = 6;
  localparam int stall_fence         = 7;
  localparam int stall_remote_req    = 8;
  localparam int stall_remote_credit = 9;
  localparam int stall_fdiv_busy     = 10;
  localparam int stall_idiv_busy     = 11;
  localparam int stall_fcsr          = 12;
  localparam int stall_barrier       = 13;

  // bubble codes double as counter indices
  typedef logic [4:0] bubble_type_t;

  localparam bubble_type_t bubble_branch_miss = 5'd0;
  localparam bubble_type_t bubble_jalr_miss   = 5'd1;
  localparam bubble_type_t bubble_icache_miss = 5'd2;
  localparam bubble_type_t bubble_stall_base  = 5'd3; // cause k -> base + k
  localparam bubble_type_t bubble_none        = 5'd17;

  localparam int num_bubble_types = 18;

  localparam int cnt_width = 32;
  typedef logic [cnt_width-1:0] cnt_t;

  typedef enum logic [1:0] {
    id_branch_miss,
    id_jalr_miss,
    id_icache_miss,
    id_none
  } id_bubble_e;

endpackage

`default_nettype wire

/* hdl/bubble_classifier.sv */
`timescale 1ns/1ps
`default_nettype none

module bubble_classifier (
  input  wire logic                         clk_i,
  input  wire logic                         reset_i,
  input  wire bubble_prof_pkg::pc_t         if_pc_i,
  input  wire bubble_prof_pkg::pc_t         id_pc_i,
  input  wire bubble_prof_pkg::pc_t         exe_pc_i,
  input  wire logic                         icache_miss_i,
  input  wire logic                         icache_miss_in_pipe_i,
  input  wire logic                         stall_all_i,
  input  wire logic                         branch_mispredict_i,
  input  wire logic                         jalr_mispredict_i,
  input  wire bubble_prof_pkg::stall_vec_t  stall_cause_i,
  output bubble_prof_pkg::bubble_type_t     exe_bubble_type_o,
  output bubble_prof_pkg::pc_t              exe_bubble_pc_o
);

  bubble_prof_pkg::pc_t         miss_pc_r;
  bubble_prof_pkg::id_bubble_e  id_bubble_r;
  bubble_prof_pkg::pc_t         id_pc_r;
  bubble_prof_pkg::bubble_type_t exe_type_r;
  bubble_prof_pkg::pc_t         exe_pc_r;

  bubble_prof_pkg::bubble_type_t stall_type;
  logic                          stall_hit;
  bubble_prof_pkg::bubble_type_t exe_type_next;
  bubble_prof_pkg::pc_t          exe_pc_next;

  // miss PC follows fetch even during a global stall
  always_ff @(posedge clk_i) begin
    if (icache_miss_i) begin
      miss_pc_r <= if_pc_i;
    end
  end

  // decode stage bubble
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      id_bubble_r <= bubble_prof_pkg::id_none;
    end else if (!stall_all_i) begin
      if (branch_mispredict_i) begin
        id_bubble_r <= bubble_prof_pkg::id_branch_miss;
        id_pc_r     <= exe_pc_i;
      end else if (jalr_mispredict_i) begin
        id_bubble_r <= bubble_prof_pkg::id_jalr_miss;
        id_pc_r     <= exe_pc_i;
      end else if (icache_miss_in_pipe_i) begin
        id_bubble_r <= bubble_prof_pkg::id_icache_miss;
        id_pc_r     <= miss_pc_r;
      end else begin
        id_bubble_r <= bubble_prof_pkg::id_none;
      end
    end
  end

  // lowest set cause wins, so scan from the top down
  always_comb begin
    stall_type = bubble_prof_pkg::bubble_none;
    for (int k = bubble_prof_pkg::num_stall_causes - 1; k >= 0; k--) begin
      if (stall_cause_i[k]) begin
        stall_type = bubble_prof_pkg::bubble_type_t'(bubble_prof_pkg::bubble_stall_base + k);
      end
    end
  end

  assign stall_hit = |stall_cause_i;

  always_comb begin
    exe_type_next = bubble_prof_pkg::bubble_none;
    exe_pc_next   = '0;
    if (branch_mispredict_i) begin
      exe_type_next = bubble_prof_pkg::bubble_branch_miss;
      exe_pc_next   = exe_pc_i;
    end else if (jalr_mispredict_i) begin
      exe_type_next = bubble_prof_pkg::bubble_jalr_miss;
      exe_pc_next   = exe_pc_i;
    end else if (id_bubble_r != bubble_prof_pkg::id_none) begin
      exe_pc_next = id_pc_r; // bubble carried from decode
      case (id_bubble_r)
        bubble_prof_pkg::id_branch_miss: exe_type_next = bubble_prof_pkg::bubble_branch_miss;
        bubble_prof_pkg::id_jalr_miss:   exe_type_next = bubble_prof_pkg::bubble_jalr_miss;
        default:                         exe_type_next = bubble_prof_pkg::bubble_icache_miss;
      endcase
    end else if (stall_hit) begin
      exe_type_next = stall_type;
      exe_pc_next   = id_pc_i;
    end
  end

  // execute stage bubble, held under stall_all
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exe_type_r <= bubble_prof_pkg::bubble_none;
      exe_pc_r   <= '0;
    end else if (!stall_all_i) begin
      exe_type_r <= exe_type_next;
      exe_pc_r   <= exe_pc_next;
    end
  end

  assign exe_bubble_type_o = exe_type_r;
  assign exe_bubble_pc_o   = exe_pc_r;

  // counter bank indexes by this code
  a_type_range: assert property (
    @(posedge clk_i) disable iff (reset_i)
    exe_bubble_type_o <= bubble_prof_pkg::bubble_none
  ) else $error("bubble type %0d out of range", exe_bubble_type_o);

  a_none_pc_zero: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (exe_bubble_type_o == bubble_prof_pkg::bubble_none) |-> (exe_bubble_pc_o == '0)
  ) else $error("no bubble but pc %h", exe_bubble_pc_o);

endmodule

`default_nettype wire

/* hdl/bubble_counter_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module bubble_counter_bank (
  input  wire logic                          clk_i,
  input  wire logic                          reset_i,
  input  wire logic                          clear_i,
  input  wire logic                          read_en_i,
  input  wire bubble_prof_pkg::bubble_type_t bubble_type_i,
  input  wire bubble_prof_pkg::bubble_type_t read_addr_i,
  output bubble_prof_pkg::cnt_t              read_data_o,
  output logic                               read_valid_o
);

  bubble_prof_pkg::cnt_t cnt_r [bubble_prof_pkg::num_bubble_types];

  // one counter per bubble type, clear beats increment
  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      for (int i = 0; i < bubble_prof_pkg::num_bubble_types; i++) begin
        cnt_r[i] <= '0;
      end
    end else begin
      for (int i = 0; i < bubble_prof_pkg::num_bubble_types; i++) begin
        if (bubble_type_i == bubble_prof_pkg::bubble_type_t'(i)) begin
          cnt_r[i] <= cnt_r[i] + bubble_prof_pkg::cnt_t'(1); // wraps
        end
      end
    end
  end

  // value from before the strobe edge
  always_ff @(posedge clk_i) begin
    if (read_en_i) begin
      read_data_o <= cnt_r[read_addr_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      read_valid_o <= 1'b0;
    end else begin
      read_valid_o <= read_en_i;
    end
  end

  a_read_addr: assert property (
    @(posedge clk_i) disable iff (reset_i)
    read_en_i |-> (read_addr_i < bubble_prof_pkg::num_bubble_types)
  ) else $error("read address %0d out of range", read_addr_i);

  // back to back valids need back to back strobes
  a_valid_pulse: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (read_valid_o && $past(read_valid_o)) |-> ($past(read_en_i) && $past(read_en_i, 2))
  ) else $error("read_valid_o held without a strobe");

endmodule

`default_nettype wire

/* hdl/bubble_profiler.sv */
`timescale 1ns/1ps
`default_nettype none

module bubble_profiler (
  input  wire logic                          clk_i,
  input  wire logic                          reset_i,
  input  wire bubble_prof_pkg::pc_t          if_pc_i,
  input  wire bubble_prof_pkg::pc_t          id_pc_i,
  input  wire bubble_prof_pkg::pc_t          exe_pc_i,
  input  wire logic                          flush_i, // implied by a mispredict
  input  wire logic                          icache_miss_i,
  input  wire logic                          icache_miss_in_pipe_i,
  input  wire logic                          stall_all_i,
  input  wire bubble_prof_pkg::stall_vec_t   stall_cause_i,
  input  wire logic                          branch_mispredict_i,
  input  wire logic                          jalr_mispredict_i,
  input  wire logic                          clear_i,
  input  wire logic                          read_en_i,
  input  wire bubble_prof_pkg::bubble_type_t read_addr_i,
  output bubble_prof_pkg::bubble_type_t      exe_bubble_type_o,
  output bubble_prof_pkg::pc_t               exe_bubble_pc_o,
  output bubble_prof_pkg::cnt_t              read_data_o,
  output logic                               read_valid_o
);

  bubble_prof_pkg::bubble_type_t exe_bubble_type;
  bubble_prof_pkg::pc_t          exe_bubble_pc;

  bubble_classifier classifier (
    .clk_i                 (clk_i),
    .reset_i               (reset_i),
    .if_pc_i               (if_pc_i),
    .id_pc_i               (id_pc_i),
    .exe_pc_i              (exe_pc_i),
    .icache_miss_i         (icache_miss_i),
    .icache_miss_in_pipe_i (icache_miss_in_pipe_i),
    .stall_all_i           (stall_all_i),
    .branch_mispredict_i   (branch_mispredict_i),
    .jalr_mispredict_i     (jalr_mispredict_i),
    .stall_cause_i         (stall_cause_i),
    .exe_bubble_type_o     (exe_bubble_type),
    .exe_bubble_pc_o       (exe_bubble_pc)
  );

  // counts every cycle, stalled or not
  bubble_counter_bank counters (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .clear_i       (clear_i),
    .read_en_i     (read_en_i),
    .bubble_type_i (exe_bubble_type),
    .read_addr_i   (read_addr_i),
    .read_data_o   (read_data_o),
    .read_valid_o  (read_valid_o)
  );

  assign exe_bubble_type_o = exe_bubble_type;
  assign exe_bubble_pc_o   = exe_bubble_pc;

endmodule

`default_nettype wire

/* tests/bubble_model.svh */
// reference state, advanced once per rising edge
bubble_prof_pkg::pc_t          m_miss_pc;
bubble_prof_pkg::id_bubble_e   m_id_state;
bubble_prof_pkg::pc_t          m_id_pc;
bubble_prof_pkg::bubble_type_t m_exe_type;
bubble_prof_pkg::pc_t          m_exe_pc;
bubble_prof_pkg::cnt_t         m_cnt [bubble_prof_pkg::num_bubble_types];
bubble_prof_pkg::cnt_t         m_read_data;
logic                          m_read_valid;

task automatic model_step();
  bubble_prof_pkg::bubble_type_t next_type;
  bubble_prof_pkg::pc_t          next_pc;
  // read port and counters see the state from before this edge
  if (read_en_i) begin
    m_read_data = m_cnt[read_addr_i];
  end
  m_read_valid = !reset_i && read_en_i;
  for (int i = 0; i < bubble_prof_pkg::num_bubble_types; i++) begin
    if (reset_i || clear_i) begin
      m_cnt[i] = '0;
    end else if (int'(m_exe_type) == i) begin
      m_cnt[i] = m_cnt[i] + 32'd1;
    end
  end
  if (reset_i) begin
    m_id_state = bubble_prof_pkg::id_none;
    m_exe_type = bubble_prof_pkg::bubble_none;
    m_exe_pc   = '0;
  end else if (!stall_all_i) begin
    next_type = bubble_prof_pkg::bubble_none;
    next_pc   = '0;
    if (branch_mispredict_i) begin
      next_type = bubble_prof_pkg::bubble_branch_miss;
      next_pc   = exe_pc_i;
    end else if (jalr_mispredict_i) begin
      next_type = bubble_prof_pkg::bubble_jalr_miss;
      next_pc   = exe_pc_i;
    end else if (m_id_state == bubble_prof_pkg::id_branch_miss) begin
      next_type = bubble_prof_pkg::bubble_branch_miss;
      next_pc   = m_id_pc;
    end else if (m_id_state == bubble_prof_pkg::id_jalr_miss) begin
      next_type = bubble_prof_pkg::bubble_jalr_miss;
      next_pc   = m_id_pc;
    end else if (m_id_state == bubble_prof_pkg::id_icache_miss) begin
      next_type = bubble_prof_pkg::bubble_icache_miss;
      next_pc   = m_id_pc;
    end else begin
      for (int k = 0; k < bubble_prof_pkg::num_stall_causes; k++) begin
        if (stall_cause_i[k] && next_type == bubble_prof_pkg::bubble_none) begin
          next_type = bubble_prof_pkg::bubble_type_t'(3 + k); // first set cause wins
          next_pc   = id_pc_i;
        end
      end
    end
    if (branch_mispredict_i) begin
      m_id_state = bubble_prof_pkg::id_branch_miss;
      m_id_pc    = exe_pc_i;
    end else if (jalr_mispredict_i) begin
      m_id_state = bubble_prof_pkg::id_jalr_miss;
      m_id_pc    = exe_pc_i;
    end else if (icache_miss_in_pipe_i) begin
      m_id_state = bubble_prof_pkg::id_icache_miss;
      m_id_pc    = m_miss_pc; // value before this edge
    end else begin
      m_id_state = bubble_prof_pkg::id_none;
    end
    m_exe_type = next_type;
    m_exe_pc   = next_pc;
  end
  if (icache_miss_i) begin
    m_miss_pc = if_pc_i;
  end
endtask

/* tests/bubble_profiler_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module bubble_profiler_tb;

  logic                          clk_i;
  logic                          reset_i;
  bubble_prof_pkg::pc_t          if_pc_i;
  bubble_prof_pkg::pc_t          id_pc_i;
  bubble_prof_pkg::pc_t          exe_pc_i;
  logic                          flush_i;
  logic                          icache_miss_i;
  logic                          icache_miss_in_pipe_i;
  logic                          stall_all_i;
  bubble_prof_pkg::stall_vec_t   stall_cause_i;
  logic                          branch_mispredict_i;
  logic                          jalr_mispredict_i;
  logic                          clear_i;
  logic                          read_en_i;
  bubble_prof_pkg::bubble_type_t read_addr_i;
  bubble_prof_pkg::bubble_type_t exe_bubble_type_o;
  bubble_prof_pkg::pc_t          exe_bubble_pc_o;
  bubble_prof_pkg::cnt_t         read_data_o;
  logic                          read_valid_o;

  integer seed;
  int     errors;
  int     timeouts;

  `include "bubble_model.svh"

  bubble_profiler DUT (
    .clk_i                 (clk_i),
    .reset_i               (reset_i),
    .if_pc_i               (if_pc_i),
    .id_pc_i               (id_pc_i),
    .exe_pc_i              (exe_pc_i),
    .flush_i               (flush_i),
    .icache_miss_i         (icache_miss_i),
    .icache_miss_in_pipe_i (icache_miss_in_pipe_i),
    .stall_all_i           (stall_all_i),
    .stall_cause_i         (stall_cause_i),
    .branch_mispredict_i   (branch_mispredict_i),
    .jalr_mispredict_i     (jalr_mispredict_i),
    .clear_i               (clear_i),
    .read_en_i             (read_en_i),
    .read_addr_i           (read_addr_i),
    .exe_bubble_type_o     (exe_bubble_type_o),
    .exe_bubble_pc_o       (exe_bubble_pc_o),
    .read_data_o           (read_data_o),
    .read_valid_o          (read_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) model_step();

  function automatic int random_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic bit random_chance(input int pct);
    return random_below(100) < pct;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_outputs();
    check_value(32'(exe_bubble_type_o), 32'(m_exe_type), "bubble type");
    check_value(exe_bubble_pc_o, m_exe_pc, "bubble pc");
    check_value(32'(read_valid_o), 32'(m_read_valid), "read valid");
    if (m_read_valid) begin
      check_value(read_data_o, m_read_data, "read data");
    end
  endtask

  task automatic drive_quiet();
    if_pc_i               = '0;
    id_pc_i               = '0;
    exe_pc_i              = '0;
    flush_i               = 1'b0;
    icache_miss_i         = 1'b0;
    icache_miss_in_pipe_i = 1'b0;
    stall_all_i           = 1'b0;
    stall_cause_i         = '0;
    branch_mispredict_i   = 1'b0;
    jalr_mispredict_i     = 1'b0;
    clear_i               = 1'b0;
    read_en_i             = 1'b0;
    read_addr_i           = '0;
  endtask

  task automatic drive_random();
    if_pc_i               = bubble_prof_pkg::pc_t'($random(seed)) & ~32'h3;
    id_pc_i               = bubble_prof_pkg::pc_t'($random(seed)) & ~32'h3;
    exe_pc_i              = bubble_prof_pkg::pc_t'($random(seed)) & ~32'h3;
    stall_all_i           = random_chance(15);
    branch_mispredict_i   = random_chance(6);
    jalr_mispredict_i     = random_chance(4);
    flush_i               = branch_mispredict_i | jalr_mispredict_i;
    icache_miss_i         = random_chance(12);
    icache_miss_in_pipe_i = random_chance(15);
    for (int k = 0; k < bubble_prof_pkg::num_stall_causes; k++) begin
      stall_cause_i[k] = random_chance(8); // often several at once
    end
    clear_i               = random_chance(1);
    read_en_i             = random_chance(25);
    read_addr_i = bubble_prof_pkg::bubble_type_t'(random_below(bubble_prof_pkg::num_bubble_types));
  endtask

  task automatic wait_read_valid(output bit ok);
    int waited;
    waited = 0;
    while (read_valid_o !== 1'b1 && waited < 16) begin
      @(negedge clk_i);
      waited++;
    end
    ok = (read_valid_o === 1'b1);
    if (!ok) begin
      $display("timeout at %0t: read_valid_o never rose after a read strobe", $time);
      timeouts++;
    end
  endtask

  task automatic read_all_counters();
    bit                    ok;
    bubble_prof_pkg::cnt_t expected;
    for (int a = 0; a < bubble_prof_pkg::num_bubble_types; a++) begin
      expected    = m_cnt[a]; // count before the strobe edge
      read_en_i   = 1'b1;
      read_addr_i = bubble_prof_pkg::bubble_type_t'(a);
      @(negedge clk_i);
      read_en_i = 1'b0;
      wait_read_valid(ok);
      if (ok) begin
        check_value(read_data_o, expected, "counter readback");
        @(negedge clk_i);
        check_value(32'(read_valid_o), 32'd0, "read valid pulse width");
      end
    end
  endtask

  initial begin
    seed     = 32'hee41;
    errors   = 0;
    timeouts = 0;
    drive_quiet();
    reset_i       = 1'b1;
    icache_miss_i = 1'b1; // gives the miss PC tracker a known start
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i       = 1'b0;
    icache_miss_i = 1'b0;

    for (int cyc = 0; cyc < 3000; cyc++) begin
      check_outputs();
      drive_random();
      @(negedge clk_i);
    end
    check_outputs();
    drive_quiet();
    @(negedge clk_i);
    read_all_counters();

    // counts after a clear come only from the cycles that follow it
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i = 1'b0;
    repeat (5) @(negedge clk_i);
    read_all_counters();

    $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+tests
hdl/bubble_prof_pkg.sv
hdl/bubble_classifier.sv
hdl/bubble_counter_bank.sv
hdl/bubble_profiler.sv
tests/bubble_profiler_tb.sv

/* Makefile */
TOP = bubble_profiler_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 -Mdir obj_dir -f verilog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf obj_dir
